//--- Bender.yml
package:
  name: rv32_core_top

export_include_dirs:
  - include

sources:
  - files:
      - hdl/core_isa_pkg.sv
      - hdl/core_ctrl_pkg.sv
      - hdl/core_intf.sv
      - hdl/alu.sv
      - hdl/fetch_stage.sv
      - hdl/id_stage.sv
      - hdl/load_store_unit.sv
      - hdl/core_top.sv
  - target: test
    files:
      - test/tb_core.sv

//--- filelist.f
+incdir+include
hdl/core_isa_pkg.sv
hdl/core_ctrl_pkg.sv
hdl/core_intf.sv
hdl/alu.sv
hdl/fetch_stage.sv
hdl/id_stage.sv
hdl/load_store_unit.sv
hdl/core_top.sv
test/tb_core.sv

//--- hdl/alu.sv
`default_nettype none

module alu import core_isa_pkg::*; (
  input  alu_op_e op_i,
  input  word_t   operand_a_i,
  input  word_t   operand_b_i,
  output word_t   result_o,
  output logic    equal_o
);

  logic less;

  // Signed compare for SLT
  assign less    = $signed(operand_a_i) < $signed(operand_b_i);
  // Branch compare
  assign equal_o = (operand_a_i == operand_b_i);

  always_comb begin
    unique case (op_i)
      ALU_ADD: result_o = operand_a_i + operand_b_i;
      ALU_SUB: result_o = operand_a_i - operand_b_i;
      ALU_AND: result_o = operand_a_i & operand_b_i;
      ALU_OR:  result_o = operand_a_i | operand_b_i;
      ALU_XOR: result_o = operand_a_i ^ operand_b_i;
      // Zero extended flags
      ALU_SLT: result_o = word_t'(less);
      ALU_EQ:  result_o = word_t'(equal_o);
      default: result_o = operand_a_i + operand_b_i;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/core_ctrl_pkg.sv
`default_nettype none

`include "core_defs.svh"

package core_ctrl_pkg;

  import core_isa_pkg::*;

  // Instruction fetch FSM
  typedef enum logic [1:0] {
    F_IDLE,
    F_WAIT_GNT,
    F_WAIT_RVALID
  } fetch_state_e;

  // Data memory FSM
  typedef enum logic [1:0] {
    L_IDLE,
    L_WAIT_GNT,
    L_WAIT_RVALID
  } lsu_state_e;

  // Decoded operation, 48 bits
  typedef struct packed {
    alu_op_e                alu_op;
    reg_addr_t              rd;
    logic                   rf_we;
    logic                   is_load;
    logic                   is_store;
    logic                   is_branch;
    logic                   branch_ne;
    logic                   is_jump;
    logic                   is_lui;
    logic                   imm_sel;
    logic [`CORE_XLEN-1:0]  imm;
  } decoded_op_t;

endpackage

`default_nettype wire

//--- hdl/core_intf.sv
`default_nettype none

// Fetch to decode handshake plus redirect path back to fetch
interface fetch_intf import core_isa_pkg::*; ();

  logic   valid;
  instr_t instr;
  word_t  pc;
  logic   ready;
  logic   redirect;
  word_t  target;

  modport fetch (
    output valid, instr, pc,
    input  ready, redirect, target
  );

  modport decode (
    input  valid, instr, pc,
    output ready, redirect, target
  );

endinterface

// Decode to load/store unit, req held until done
interface lsu_intf import core_isa_pkg::*; ();

  logic  req;
  logic  we;
  word_t addr;
  word_t wdata;
  logic  done;
  word_t rdata;

  modport core (
    output req, we, addr, wdata,
    input  done, rdata
  );

  modport unit (
    input  req, we, addr, wdata,
    output done, rdata
  );

endinterface

`default_nettype wire

//--- hdl/core_isa_pkg.sv
`default_nettype none

`include "core_defs.svh"

package core_isa_pkg;

  // Basic field types
  typedef logic [`CORE_XLEN-1:0]   word_t;
  typedef logic [`CORE_ILEN-1:0]   instr_t;
  typedef logic [`CORE_REG_AW-1:0] reg_addr_t;
  typedef logic [2:0]              funct3_t;
  typedef logic [6:0]              funct7_t;

  // Major opcodes of the supported subset
  // Low two bits are 11, compressed encodings never match
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // ALU function select
  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SLT = 3'd5,
    ALU_EQ  = 3'd6
  } alu_op_e;

  // funct3 codes, several share one value across opcodes
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;
  localparam funct3_t F3_LW      = 3'b010;
  localparam funct3_t F3_SW      = 3'b010;
  localparam funct3_t F3_BEQ     = 3'b000;
  localparam funct3_t F3_BNE     = 3'b001;

  // funct7 codes for register-register ops
  localparam funct7_t F7_BASE = 7'b0000000;
  localparam funct7_t F7_SUB  = 7'b0100000;

endpackage

`default_nettype wire

//--- hdl/core_top.sv
`default_nettype none

module core_top import core_isa_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  fetch_enable_i,
  input  word_t boot_addr_i,
  // Instruction memory
  output logic  instr_req_o,
  input  logic  instr_gnt_i,
  input  logic  instr_rvalid_i,
  output word_t instr_addr_o,
  input  word_t instr_rdata_i,
  // Data memory, word access only
  output logic  data_req_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  output logic  data_we_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  word_t data_rdata_i
);

  // Stage links
  fetch_intf fetch_if ();
  lsu_intf   lsu_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Fetch
  ////////////////////////////////////////////////////////////////////////////

  fetch_stage u_fetch_stage (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .fetch          (fetch_if)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Decode, execute, write-back
  ////////////////////////////////////////////////////////////////////////////

  id_stage u_id_stage (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .fetch  (fetch_if),
    .lsu    (lsu_if)
  );

  // Data memory port
  load_store_unit u_load_store_unit (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lsu           (lsu_if),
    .data_req_o    (data_req_o),
    .data_gnt_i    (data_gnt_i),
    .data_rvalid_i (data_rvalid_i),
    .data_we_o     (data_we_o),
    .data_addr_o   (data_addr_o),
    .data_wdata_o  (data_wdata_o),
    .data_rdata_i  (data_rdata_i)
  );

endmodule

`default_nettype wire

//--- hdl/fetch_stage.sv
`default_nettype none

module fetch_stage import core_isa_pkg::*; import core_ctrl_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     fetch_enable_i,
  input  word_t    boot_addr_i,
  // Instruction memory
  output logic     instr_req_o,
  output word_t    instr_addr_o,
  input  logic     instr_gnt_i,
  input  logic     instr_rvalid_i,
  input  word_t    instr_rdata_i,
  // To decode
  fetch_intf.fetch fetch
);

  fetch_state_e state_q, state_d;

  word_t  pc_q;
  word_t  addr_q;
  word_t  fetch_addr;
  word_t  buf_pc_q;
  instr_t buf_instr_q;
  logic   boot_q;
  logic   buf_valid_q;
  logic   stale_q;
  logic   issue;
  logic   accept;

  // Next fetch address, redirect has priority over sequential PC
  assign fetch_addr = fetch.redirect ? fetch.target : (boot_q ? boot_addr_i : pc_q);

  // Response lands in buffer unless made stale by a redirect
  assign accept = (state_q == F_WAIT_RVALID) && instr_rvalid_i && !stale_q && !fetch.redirect;

  always_comb begin
    state_d = state_q;
    issue   = 1'b0;
    unique case (state_q)
      // Buffer free now or handed over this cycle
      F_IDLE: begin
        issue   = fetch_enable_i && (!buf_valid_q || fetch.ready);
        state_d = issue ? F_WAIT_GNT : F_IDLE;
      end
      F_WAIT_GNT: begin
        state_d = instr_gnt_i ? F_WAIT_RVALID : F_WAIT_GNT;
      end
      // Prefetch only if decode will take the new word next cycle
      F_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          issue   = fetch_enable_i && fetch.ready && !buf_valid_q;
          state_d = issue ? F_WAIT_GNT : F_IDLE;
        end
      end
      default: state_d = F_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= F_IDLE;
      boot_q      <= 1'b1;
      pc_q        <= '0;
      addr_q      <= '0;
      buf_valid_q <= 1'b0;
      stale_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      // Request address held until grant
      if (issue) begin
        boot_q <= 1'b0;
        addr_q <= fetch_addr;
        pc_q   <= fetch_addr + word_t'(4);
      end else if (fetch.redirect) begin
        pc_q <= fetch.target;
      end
      // Redirect drops the buffered word
      if (accept) begin
        buf_valid_q <= 1'b1;
      end else if (fetch.redirect || (buf_valid_q && fetch.ready)) begin
        buf_valid_q <= 1'b0;
      end
      // Outstanding response becomes stale on redirect
      if ((state_q == F_WAIT_RVALID) && instr_rvalid_i) begin
        stale_q <= 1'b0;
      end else if (fetch.redirect && (state_q != F_IDLE)) begin
        stale_q <= 1'b1;
      end
    end
  end

  // Buffer payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      buf_instr_q <= instr_rdata_i;
      buf_pc_q    <= addr_q;
    end
  end

  assign instr_req_o  = (state_q == F_WAIT_GNT);
  assign instr_addr_o = addr_q;
  assign fetch.valid  = buf_valid_q;
  assign fetch.instr  = buf_instr_q;
  assign fetch.pc     = buf_pc_q;

  // No response without a granted request
  a_rvalid_expected : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> (state_q == F_WAIT_RVALID)
  );

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
`default_nettype none

`include "core_defs.svh"

module id_stage import core_isa_pkg::*; import core_ctrl_pkg::*; #(
  parameter int unsigned NUM_REGS = `CORE_NREGS
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  fetch_intf.decode fetch,
  lsu_intf.core     lsu
);

  instr_t      instr;
  opcode_e     opcode;
  funct3_t     funct3;
  funct7_t     funct7;
  reg_addr_t   rs1, rs2;
  word_t       imm_i, imm_s, imm_b, imm_u, imm_j;
  decoded_op_t dec;
  word_t       rf_q [NUM_REGS];
  word_t       rs1_val, rs2_val, operand_b, alu_result;
  logic        alu_equal, transfer, taken;
  logic        busy_q, lsu_we_q;
  word_t       lsu_addr_q, lsu_wdata_q;
  reg_addr_t   load_rd_q;
  logic        wb_en;
  reg_addr_t   wb_addr;
  word_t       wb_data;

  ////////////////////////////////////////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////////////////////////////////////////

  assign instr  = fetch.instr;
  assign opcode = opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // Sign extended immediates per format
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Unsupported encodings fall out as a no-op
  always_comb begin
    dec        = '0;
    dec.alu_op = ALU_ADD;
    dec.rd     = instr[11:7];
    unique case (opcode)
      OPC_OP: begin
        if (funct7 == F7_BASE || (funct7 == F7_SUB && funct3 == F3_ADD_SUB)) begin
          dec.rf_we = 1'b1;
          unique case (funct3)
            F3_ADD_SUB: dec.alu_op = funct7[5] ? ALU_SUB : ALU_ADD;
            F3_SLT:     dec.alu_op = ALU_SLT;
            F3_XOR:     dec.alu_op = ALU_XOR;
            F3_OR:      dec.alu_op = ALU_OR;
            F3_AND:     dec.alu_op = ALU_AND;
            default:    dec.rf_we  = 1'b0;
          endcase
        end
      end
      // ADDI only
      OPC_OP_IMM: begin
        dec.rf_we   = (funct3 == F3_ADD_SUB);
        dec.imm_sel = 1'b1;
        dec.imm     = imm_i;
      end
      OPC_LUI: begin
        dec.rf_we  = 1'b1;
        dec.is_lui = 1'b1;
        dec.imm    = imm_u;
      end
      // Word loads and stores, address from the adder
      OPC_LOAD: begin
        dec.is_load = (funct3 == F3_LW);
        dec.rf_we   = (funct3 == F3_LW);
        dec.imm_sel = 1'b1;
        dec.imm     = imm_i;
      end
      OPC_STORE: begin
        dec.is_store = (funct3 == F3_SW);
        dec.imm_sel  = 1'b1;
        dec.imm      = imm_s;
      end
      OPC_BRANCH: begin
        dec.is_branch = (funct3 == F3_BEQ) || (funct3 == F3_BNE);
        dec.branch_ne = (funct3 == F3_BNE);
        dec.alu_op    = ALU_EQ;
        dec.imm       = imm_b;
      end
      // Link value written back below
      OPC_JAL: begin
        dec.rf_we   = 1'b1;
        dec.is_jump = 1'b1;
        dec.imm     = imm_j;
      end
      default: dec.rd = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Register file and execute
  ////////////////////////////////////////////////////////////////////////////

  // x0 hardwired to zero on read
  assign rs1_val   = (rs1 == '0) ? '0 : rf_q[rs1];
  assign rs2_val   = (rs2 == '0) ? '0 : rf_q[rs2];
  assign operand_b = dec.imm_sel ? dec.imm : rs2_val;

  alu u_alu (
    .op_i        (dec.alu_op),
    .operand_a_i (rs1_val),
    .operand_b_i (operand_b),
    .result_o    (alu_result),
    .equal_o     (alu_equal)
  );

  // Retire on handshake
  assign transfer = fetch.valid && fetch.ready;
  assign taken    = (dec.is_branch && (alu_equal ^ dec.branch_ne)) || dec.is_jump;

  // Branch and JAL share the PC-relative target
  assign fetch.ready    = !busy_q;
  assign fetch.redirect = transfer && taken;
  assign fetch.target   = fetch.pc + dec.imm;

  // Load result or ALU, LUI, link value
  always_comb begin
    wb_en   = 1'b0;
    wb_addr = dec.rd;
    wb_data = alu_result;
    if (lsu.done && !lsu_we_q) begin
      wb_en   = 1'b1;
      wb_addr = load_rd_q;
      wb_data = lsu.rdata;
    end else if (transfer && dec.rf_we && !dec.is_load) begin
      wb_en   = 1'b1;
      wb_data = dec.is_lui ? dec.imm : (dec.is_jump ? fetch.pc + word_t'(4) : alu_result);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wb_en) begin
      rf_q[wb_addr] <= wb_data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Memory request and stall
  ////////////////////////////////////////////////////////////////////////////

  // Busy from a load/store handshake until done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      lsu_we_q <= 1'b0;
    end else if (transfer && (dec.is_load || dec.is_store)) begin
      busy_q   <= 1'b1;
      lsu_we_q <= dec.is_store;
    end else if (lsu.done) begin
      busy_q <= 1'b0;
    end
  end

  // Request fields, stable while busy
  always_ff @(posedge clk_i) begin
    if (transfer && (dec.is_load || dec.is_store)) begin
      lsu_addr_q  <= alu_result;
      lsu_wdata_q <= rs2_val;
      load_rd_q   <= dec.rd;
    end
  end

  assign lsu.req   = busy_q;
  assign lsu.we    = lsu_we_q;
  assign lsu.addr  = lsu_addr_q;
  assign lsu.wdata = lsu_wdata_q;

  // Done answers only a pending request while fetch is held off
  a_done_while_pending : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    lsu.done |-> lsu.req && !fetch.ready
  );

endmodule

`default_nettype wire

//--- hdl/load_store_unit.sv
`default_nettype none

module load_store_unit import core_isa_pkg::*; import core_ctrl_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_ni,
  lsu_intf.unit lsu,
  // Data memory
  output logic  data_req_o,
  input  logic  data_gnt_i,
  input  logic  data_rvalid_i,
  output logic  data_we_o,
  output word_t data_addr_o,
  output word_t data_wdata_o,
  input  word_t data_rdata_i
);

  lsu_state_e state_q, state_d;

  logic  we_q;
  logic  done_q;
  logic  start;
  word_t addr_q;
  word_t wdata_q;
  word_t rdata_q;

  // Request still high in the done cycle, not a new one
  assign start = (state_q == L_IDLE) && lsu.req && !done_q;

  // Stores also wait for their rvalid, one access outstanding
  always_comb begin
    state_d = state_q;
    unique case (state_q)
      L_IDLE:        state_d = start ? L_WAIT_GNT : L_IDLE;
      L_WAIT_GNT:    state_d = data_gnt_i ? L_WAIT_RVALID : L_WAIT_GNT;
      L_WAIT_RVALID: state_d = data_rvalid_i ? L_IDLE : L_WAIT_RVALID;
      default:       state_d = L_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= L_IDLE;
      we_q    <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (start) begin
        we_q <= lsu.we;
      end
      // Store done after grant, load done after response
      done_q <= ((state_q == L_WAIT_GNT) && data_gnt_i && we_q) ||
                ((state_q == L_WAIT_RVALID) && data_rvalid_i && !we_q);
    end
  end

  // Address, write data and load data
  always_ff @(posedge clk_i) begin
    if (start) begin
      addr_q  <= lsu.addr;
      wdata_q <= lsu.wdata;
    end
    if ((state_q == L_WAIT_RVALID) && data_rvalid_i && !we_q) begin
      rdata_q <= data_rdata_i;
    end
  end

  assign data_req_o   = (state_q == L_WAIT_GNT);
  assign data_we_o    = we_q;
  assign data_addr_o  = addr_q;
  assign data_wdata_o = wdata_q;
  assign lsu.done     = done_q;
  assign lsu.rdata    = rdata_q;

  // Bus rule, request and address held until grant
  a_req_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    data_req_o && !data_gnt_i |=> data_req_o && $stable(data_addr_o)
  );

endmodule

`default_nettype wire

//--- include/core_defs.svh
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Data path and address width
`define CORE_XLEN 32

// Architectural integer registers
`define CORE_NREGS 32

// Register index width, log2 of CORE_NREGS
`define CORE_REG_AW 5

// Instruction word width
// Only full-size encodings are decoded
`define CORE_ILEN 32

`endif

//--- test/core_stim.txt
// Word image for $readmemh, @00 program words from the boot address, @40 initial data words
// @48 expected store count, @49 rows of three columns: test id, store address, store data
@00
123450B7 06400113 FF900193 00310233
403102B3 0021A333 003143B3 00316433
003174B3 04102023 04402223 04502423
04602623 04702823 04802A23 04902C23
00002503 00402583 00B50633 04A02E23
06C02023 00310463 06202223 00311463
06102E23 00210463 06102E23 00319463
06302423 00C006EF 06102E23 06102E23
06D02623 00111113 06202823 0E002E23
0000006F
@40
12345678 FFFFFFF0 0000ABCD 80000001 00000000 FFFFFFFF 55AA55AA 0F0F0F0F
@48
0000000D
// id 2 ALU and LUI, id 3 loads, id 4 control flow
00000002 00000040 12345000
00000002 00000044 0000005D
00000002 00000048 0000006B
00000002 0000004C 00000001
00000002 00000050 FFFFFF9D
00000002 00000054 FFFFFFFD
00000002 00000058 00000060
00000003 0000005C 12345678
00000003 00000060 12345668
00000004 00000064 00000064
00000004 00000068 FFFFFFF9
00000004 0000006C 00000178
00000002 00000070 00000064

//--- test/tb_core.sv
`default_nettype none

module tb_core;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned CLK_HALF    = 50;
  localparam int unsigned DRIVE_DELAY = 10;
  localparam logic [31:0] BOOT_ADDR   = 32'h0000_0100;
  // Store here ends the program
  localparam logic [31:0] END_ADDR    = 32'h0000_00fc;
  localparam int unsigned REQ_TIMEOUT = 20;
  localparam int unsigned RUN_TIMEOUT = 2000;
  // Stimulus image layout in words
  localparam int unsigned STIM_WORDS  = 128;
  localparam int unsigned PROG_WORDS  = 64;
  localparam int unsigned DATA_BASE   = 64;
  localparam int unsigned DATA_WORDS  = 8;
  localparam int unsigned EXP_COUNT   = 72;
  localparam int unsigned EXP_BASE    = 73;

  logic        clk_i, rst_ni, fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic        data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;

  logic [31:0] stim_mem [STIM_WORDS];
  logic [31:0] imem [PROG_WORDS];
  logic [31:0] dmem [64];
  logic [31:0] exp_tag[$], exp_addr[$], exp_data[$];
  logic [31:0] obs_addr[$], obs_data[$];
  time         obs_time[$];

  integer      seed = 32'h0aaf48bd;
  int unsigned errors, hold_errors, tests_run, tests_failed;
  bit          end_seen, timed_out;

  // Memory port state
  int unsigned i_gnt_wait, i_resp_wait, d_gnt_wait, d_resp_wait;
  bit          i_gnt_armed, i_resp_pend, d_gnt_armed, d_resp_pend, d_hold;
  logic [31:0] i_resp_data, d_resp_data, d_hold_addr;

  core_top u_dut (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .fetch_enable_i (fetch_enable_i),
    .boot_addr_i    (boot_addr_i),
    .instr_req_o    (instr_req_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_addr_o   (instr_addr_o),
    .instr_rdata_i  (instr_rdata_i),
    .data_req_o     (data_req_o),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_we_o      (data_we_o),
    .data_addr_o    (data_addr_o),
    .data_wdata_o   (data_wdata_o),
    .data_rdata_i   (data_rdata_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks and reporting
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_word(input time t, input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %0t %s: expected %h, got %h", t, name, exp, got);
      errors++;
    end
  endtask

  task automatic check_true(input bit cond, input string what);
    assert (cond) else begin
      $display("Check failed at %0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int unsigned err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // Stores are compared by position in the sequence
  task automatic compare_group(input logic [31:0] tag);
    for (int k = 0; k < exp_addr.size(); k++) begin
      if (exp_tag[k] == tag) begin
        check_true(k < obs_addr.size(),
                   $sformatf("expected store %0d to %h never happened", k, exp_addr[k]));
        if (k < obs_addr.size()) begin
          check_word(obs_time[k], $sformatf("data_addr_o (store %0d)", k),
                     obs_addr[k], exp_addr[k]);
          check_word(obs_time[k], $sformatf("data_wdata_o (store %0d)", k),
                     obs_data[k], exp_data[k]);
        end
      end
    end
  endtask

  // Skipped paths store to addresses not in the list
  task automatic check_no_stray_stores();
    bit found;
    for (int k = 0; k < obs_addr.size(); k++) begin
      found = 1'b0;
      foreach (exp_addr[j]) begin
        if (exp_addr[j] == obs_addr[k]) begin
          found = 1'b1;
        end
      end
      check_true(found, $sformatf("unexpected store to %h at %0t", obs_addr[k], obs_time[k]));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory models
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_stimulus();
    int unsigned n;
    for (int i = 0; i < STIM_WORDS; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("test/core_stim.txt", stim_mem);
    for (int i = 0; i < PROG_WORDS; i++) begin
      imem[i] = stim_mem[i];
    end
    // Background differs per word address
    for (int i = 0; i < 64; i++) begin
      dmem[i] = 32'hdead_0000 ^ 32'(i << 2);
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      dmem[i] = stim_mem[DATA_BASE + i];
    end
    n = stim_mem[EXP_COUNT];
    for (int k = 0; k < n; k++) begin
      exp_tag.push_back(stim_mem[EXP_BASE + 3 * k]);
      exp_addr.push_back(stim_mem[EXP_BASE + 3 * k + 1]);
      exp_data.push_back(stim_mem[EXP_BASE + 3 * k + 2]);
    end
  endtask

  // Words outside the program read as zero
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    logic [31:0] offset;
    offset = addr - BOOT_ADDR;
    if (offset[31:2] < PROG_WORDS) begin
      fetch_word = imem[offset[7:2]];
    end else begin
      fetch_word = '0;
    end
  endfunction

  task automatic serve_instr_port();
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    if (i_resp_pend) begin
      if (i_resp_wait == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = i_resp_data;
        i_resp_pend    = 1'b0;
      end else begin
        i_resp_wait--;
      end
    end else if (instr_req_o) begin
      if (!i_gnt_armed) begin
        i_gnt_wait  = $unsigned($random(seed)) % 4;
        i_gnt_armed = 1'b1;
      end
      if (i_gnt_wait == 0) begin
        instr_gnt_i = 1'b1;
        i_gnt_armed = 1'b0;
        i_resp_pend = 1'b1;
        i_resp_wait = $unsigned($random(seed)) % 4;
        i_resp_data = fetch_word(instr_addr_o);
      end else begin
        i_gnt_wait--;
      end
    end
  endtask

  task automatic serve_data_port();
    logic [5:0] idx;
    // A waiting request keeps its address
    if (d_hold) begin
      assert (data_req_o) else begin
        $display("Check failed at %0t: data_req_o dropped before its grant", $time);
        errors++;
        hold_errors++;
      end
      assert (data_addr_o === d_hold_addr) else begin
        $display("[ERROR] %0t data_addr_o: expected %h, got %h", $time, d_hold_addr,
                 data_addr_o);
        errors++;
        hold_errors++;
      end
    end
    data_gnt_i    = 1'b0;
    data_rvalid_i = 1'b0;
    idx           = data_addr_o[7:2];
    if (d_resp_pend) begin
      if (d_resp_wait == 0) begin
        data_rvalid_i = 1'b1;
        data_rdata_i  = d_resp_data;
        d_resp_pend   = 1'b0;
      end else begin
        d_resp_wait--;
      end
    end else if (data_req_o) begin
      if (!d_gnt_armed) begin
        d_gnt_wait  = $unsigned($random(seed)) % 4;
        d_gnt_armed = 1'b1;
      end
      if (d_gnt_wait == 0) begin
        data_gnt_i  = 1'b1;
        d_gnt_armed = 1'b0;
        d_resp_pend = 1'b1;
        d_resp_wait = $unsigned($random(seed)) % 4;
        if (data_we_o) begin
          dmem[idx] = data_wdata_o;
          if (data_addr_o == END_ADDR) begin
            end_seen = 1'b1;
          end else begin
            obs_addr.push_back(data_addr_o);
            obs_data.push_back(data_wdata_o);
            obs_time.push_back($time);
          end
        end else begin
          d_resp_data = dmem[idx];
        end
      end else begin
        d_gnt_wait--;
      end
    end
    d_hold      = data_req_o && !data_gnt_i;
    d_hold_addr = data_addr_o;
  endtask

  // One process for both ports keeps the random sequence fixed
  initial begin
    forever begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      serve_instr_port();
      serve_data_port();
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int unsigned err_before;
    int unsigned cycles;
    rst_ni         = 1'b0;
    fetch_enable_i = 1'b1;
    boot_addr_i    = BOOT_ADDR;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    data_rvalid_i  = 1'b0;
    data_rdata_i   = '0;
    load_stimulus();

    // Reset and boot request
    err_before = errors;
    repeat (3) begin
      @(posedge clk_i);
      #(DRIVE_DELAY);
      check_word($time, "instr_req_o", 32'(instr_req_o), 32'h0);
      check_word($time, "data_req_o", 32'(data_req_o), 32'h0);
    end
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_word($time, "instr_req_o", 32'(instr_req_o), 32'h0);
    check_word($time, "data_req_o", 32'(data_req_o), 32'h0);
    check_word($time, "data_we_o", 32'(data_we_o), 32'h0);
    cycles = 0;
    while (!instr_req_o && cycles < REQ_TIMEOUT) begin
      @(negedge clk_i);
      cycles++;
    end
    if (!instr_req_o) begin
      $display("Timeout: no instruction request within %0d cycles of reset", REQ_TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end else begin
      check_word($time, "instr_addr_o", instr_addr_o, BOOT_ADDR);
    end
    finish_test("1 reset and boot address", err_before);

    // Program runs until the end store
    if (!timed_out) begin
      cycles = 0;
      while (!end_seen && cycles < RUN_TIMEOUT) begin
        @(negedge clk_i);
        cycles++;
      end
      if (!end_seen) begin
        $display("Timeout: program did not reach its end store in %0d cycles", RUN_TIMEOUT);
        errors++;
        timed_out = 1'b1;
      end
    end

    if (!timed_out) begin
      err_before = errors;
      compare_group(32'd2);
      finish_test("2 ALU and LUI results", err_before);
      err_before = errors;
      compare_group(32'd3);
      finish_test("3 loads", err_before);
      err_before = errors;
      compare_group(32'd4);
      check_no_stray_stores();
      finish_test("4 control flow", err_before);
      err_before = errors;
      check_true(obs_addr.size() == exp_addr.size(),
                 $sformatf("saw %0d stores, expected %0d", obs_addr.size(), exp_addr.size()));
      check_true(hold_errors == 0, "a data request changed before its grant");
      finish_test("5 back-pressure", err_before);
    end

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors", tests_run,
             tests_run - tests_failed, tests_failed, errors);
    if (errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
